//--- common/ras_mem_config.svh
`ifndef RAS_MEM_CONFIG_SVH
`define RAS_MEM_CONFIG_SVH

// --------------------
// Word store geometry
// --------------------

// Host data word and SECDED check field widths
`define RM_DATA_BITS        64
`define RM_CHECK_BITS       8

// Word address width and number of words in the store
`define RM_ADDR_BITS        10
`define RM_DEPTH            1024

// --------------------
// Scrub and RAS policy
// --------------------

// Consecutive refusals of a waiting scrub request before it is forced through
`define RM_SCRUB_STARVE     16

// Correctable error count that raises irq_corr
`define RM_CORR_THRESHOLD   4

// Register indexes on reg_addr, all other indexes read as zero
`define RM_REG_CORR_CNT     8'd0
`define RM_REG_UNCORR_CNT   8'd1
`define RM_REG_ERR_ADDR     8'd2
`define RM_REG_SYNDROME     8'd3
`define RM_REG_SCRUB_PASSES 8'd4
`define RM_REG_STATUS       8'd5

`endif

//--- common/ras_mem_pkg.sv
`include "ras_mem_config.svh"

package ras_mem_pkg;

    // One host data word as seen outside the store
    typedef logic [`RM_DATA_BITS-1:0] word_t;

    // SECDED check bits, the same width also carries the syndrome
    typedef logic [`RM_CHECK_BITS-1:0] check_t;

    // Word address into the store
    typedef logic [`RM_ADDR_BITS-1:0] addr_t;

    // Command kinds, the two flip kinds poison the stored data after encoding
    typedef enum logic [1:0] {
        cmd_read        = 2'd0,
        cmd_write       = 2'd1,
        cmd_write_flip1 = 2'd2,
        cmd_write_flip2 = 2'd3
    } cmd_kind_t;

    // Origin of a request, carried through the read pipeline
    typedef enum logic {
        src_host  = 1'b0,
        src_scrub = 1'b1
    } req_src_t;

    // One read response out of the decode stage
    typedef struct packed {
        logic     valid;
        req_src_t src;
        addr_t    addr;
        // Corrected data when the error was correctable, raw data otherwise
        word_t    data;
        logic     single_err;
        logic     double_err;
        check_t   syndrome;
    } mem_rsp_t;

endpackage

//--- common/mem_req_if.sv
`timescale 1ns/10ps

// Request channel between a requester, the arbiter and the word store
interface mem_req_if;

    // Fields held stable by the initiator while valid is high and ready is low
    logic                   valid;
    ras_mem_pkg::cmd_kind_t kind;
    ras_mem_pkg::addr_t     addr;
    ras_mem_pkg::word_t     wdata;

    // Request origin, only the arbiter drives this
    ras_mem_pkg::req_src_t  src;

    // A transfer happens on an edge where valid and ready are both high
    logic                   ready;

    modport initiator (output valid, kind, addr, wdata, src, input ready);

    modport target (input valid, kind, addr, wdata, src, output ready);

    // Passive view, used to watch grants on the store side
    modport monitor (input valid, kind, addr, wdata, src, ready);

endinterface

//--- ecc/secded_encoder.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module secded_encoder (
    input  ras_mem_pkg::word_t  data,
    output ras_mem_pkg::check_t check
);

    // Hamming positions run from 1 up to this value in the codeword
    localparam int LAST_POS = `RM_DATA_BITS + `RM_CHECK_BITS - 1;

    // Number of Hamming parity bits, the top check bit is overall parity
    localparam int HAM_BITS = `RM_CHECK_BITS - 1;

    always_comb begin
        logic [LAST_POS:1]   code;
        int                  di;
        ras_mem_pkg::check_t par;
        code = '0;
        par  = '0;
        di   = 0;
        // Data fills every position that is not a power of two
        for (int pos = 1; pos <= LAST_POS; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                code[pos] = data[di];
                di = di + 1;
            end
        end
        // Parity bit p covers all positions whose index has bit p set
        for (int p = 0; p < HAM_BITS; p++) begin
            for (int pos = 1; pos <= LAST_POS; pos++) begin
                if (((pos >> p) & 1) == 1) begin
                    par[p] = par[p] ^ code[pos];
                end
            end
        end
        // Overall parity over the data and the Hamming bits
        par[HAM_BITS] = (^data) ^ (^par[HAM_BITS-1:0]);
        check = par;
    end

endmodule

//--- ecc/secded_decoder.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module secded_decoder (
    input  ras_mem_pkg::word_t  data,
    input  ras_mem_pkg::check_t check,
    output ras_mem_pkg::word_t  corrected,
    output ras_mem_pkg::check_t syndrome,
    output logic                single_err,
    output logic                double_err
);

    localparam int LAST_POS = `RM_DATA_BITS + `RM_CHECK_BITS - 1;
    localparam int HAM_BITS = `RM_CHECK_BITS - 1;

    ras_mem_pkg::check_t recomputed;
    logic                parity_err;
    logic                ham_nonzero;

    // Check bits of the data as it was read back
    secded_encoder u_recompute (
        .data  (data),
        .check (recomputed)
    );

    assign syndrome = recomputed ^ check;

    // XOR of the whole syndrome equals the parity of the received codeword,
    // so it is odd for any odd number of flipped bits
    assign parity_err  = ^syndrome;
    assign ham_nonzero = |syndrome[HAM_BITS-1:0];

    // Odd parity is a single error, whether in data, Hamming or overall bit
    assign single_err = parity_err;

    // Even parity with a nonzero Hamming part means two bits flipped
    assign double_err = ham_nonzero && !parity_err;

    // --------------------
    // Single bit repair
    // --------------------

    always_comb begin
        int di;
        corrected = data;
        di        = 0;
        // Walk the data positions and invert the one the syndrome names.
        // A power of two position is a check bit and leaves data untouched
        for (int pos = 1; pos <= LAST_POS; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                if (single_err && (syndrome[HAM_BITS-1:0] == HAM_BITS'(pos))) begin
                    corrected[di] = ~data[di];
                end
                di = di + 1;
            end
        end
    end

endmodule

//--- source/cmd_arbiter.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module cmd_arbiter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   cmd_valid,
    input  ras_mem_pkg::cmd_kind_t cmd_kind,
    input  ras_mem_pkg::addr_t     cmd_addr,
    input  ras_mem_pkg::word_t     cmd_wdata,
    output logic                   cmd_ready,
    mem_req_if.target              scrub,
    mem_req_if.initiator           store
);

    localparam int STARVE_W = $clog2(`RM_SCRUB_STARVE + 1);

    logic [STARVE_W-1:0] refuse_cnt;
    logic                force_scrub;
    logic                host_sel;

    // The scrubber wins outright once it has waited long enough
    assign force_scrub = scrub.valid && (refuse_cnt >= STARVE_W'(`RM_SCRUB_STARVE));

    // Host has priority in every other cycle
    assign host_sel  = cmd_valid && !force_scrub;
    assign cmd_ready = store.ready && !force_scrub;

    // Scrubber gets the store whenever the host does not take it
    assign scrub.ready = store.ready && !host_sel;

    // Grant mux toward the store, tagging the origin
    assign store.valid = host_sel || scrub.valid;
    assign store.kind  = host_sel ? cmd_kind : scrub.kind;
    assign store.addr  = host_sel ? cmd_addr : scrub.addr;
    assign store.wdata = host_sel ? cmd_wdata : scrub.wdata;
    assign store.src   = host_sel ? ras_mem_pkg::src_host : ras_mem_pkg::src_scrub;

    // Count consecutive cycles where a valid scrub request was turned away
    always_ff @(posedge CLK) begin
        if (RESET) begin
            refuse_cnt <= '0;
        end else if (scrub.valid && !scrub.ready) begin
            refuse_cnt <= refuse_cnt + 1'b1;
        end else begin
            refuse_cnt <= '0;
        end
    end

endmodule

//--- source/protected_store.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module protected_store (
    input  logic                  CLK,
    input  logic                  RESET,
    mem_req_if.target             req,
    output ras_mem_pkg::mem_rsp_t rsp
);

    localparam int CW_BITS = `RM_DATA_BITS + `RM_CHECK_BITS;

    // Check bits in the upper field, data in the lower field
    logic [CW_BITS-1:0]    mem [`RM_DEPTH];

    ras_mem_pkg::check_t   wr_check;
    ras_mem_pkg::word_t    flip;
    logic                  accept;

    // Accepted read, the array is read from this address on the next edge
    logic                  a_valid;
    ras_mem_pkg::req_src_t a_src;
    ras_mem_pkg::addr_t    a_addr;

    // Array read stage
    logic                  c_valid;
    ras_mem_pkg::req_src_t c_src;
    ras_mem_pkg::addr_t    c_addr;
    logic [CW_BITS-1:0]    c_code;

    ras_mem_pkg::word_t    dec_data;
    ras_mem_pkg::check_t   dec_syn;
    logic                  dec_single;
    logic                  dec_double;

    // The store never stalls
    assign req.ready = 1'b1;
    assign accept    = req.valid && req.ready;

    secded_encoder u_enc (
        .data  (req.wdata),
        .check (wr_check)
    );

    // Poison pattern applied after encoding for error injection
    always_comb begin
        case (req.kind)
            ras_mem_pkg::cmd_write_flip1: flip = ras_mem_pkg::word_t'(1);
            ras_mem_pkg::cmd_write_flip2: flip = ras_mem_pkg::word_t'(3);
            default:                      flip = '0;
        endcase
    end

    // All zero is a valid codeword, so a cleared array decodes clean
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < `RM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && (req.kind != ras_mem_pkg::cmd_read)) begin
            mem[req.addr] <= {wr_check, req.wdata ^ flip};
        end
    end

    // --------------------
    // Read pipeline
    // --------------------

    always_ff @(posedge CLK) begin
        if (RESET) begin
            a_valid   <= 1'b0;
            c_valid   <= 1'b0;
            rsp.valid <= 1'b0;
        end else begin
            a_valid   <= accept && (req.kind == ras_mem_pkg::cmd_read);
            c_valid   <= a_valid;
            rsp.valid <= c_valid;
        end
        // Payload follows its valid bit without a reset
        a_src          <= req.src;
        a_addr         <= req.addr;
        c_src          <= a_src;
        c_addr         <= a_addr;
        c_code         <= mem[a_addr];
        rsp.src        <= c_src;
        rsp.addr       <= c_addr;
        rsp.data       <= dec_data;
        rsp.single_err <= dec_single;
        rsp.double_err <= dec_double;
        rsp.syndrome   <= dec_syn;
    end

    secded_decoder u_dec (
        .data       (c_code[`RM_DATA_BITS-1:0]),
        .check      (c_code[CW_BITS-1:`RM_DATA_BITS]),
        .corrected  (dec_data),
        .syndrome   (dec_syn),
        .single_err (dec_single),
        .double_err (dec_double)
    );

endmodule

//--- source/patrol_scrubber.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module patrol_scrubber (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  enable,
    mem_req_if.initiator          req,
    mem_req_if.monitor            bus,
    input  ras_mem_pkg::mem_rsp_t rsp,
    output logic                  scrub_active,
    output logic                  pass_done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WBACK
    } state_t;

    state_t             state;
    ras_mem_pkg::addr_t cur_addr;
    ras_mem_pkg::word_t wb_data;
    logic               rd_sent;
    logic               hit;
    logic               host_wr_hit;
    logic               scrub_rsp;
    logic               step_done;

    // A host write to the location under repair landed in the store this cycle
    assign host_wr_hit = bus.valid && bus.ready && (bus.src == ras_mem_pkg::src_host)
                         && (bus.kind != ras_mem_pkg::cmd_read) && (bus.addr == cur_addr);

    assign scrub_rsp = rsp.valid && (rsp.src == ras_mem_pkg::src_scrub);

    // One read outstanding, and the write-back once a repair is due
    assign req.valid = ((state == ST_READ) && !rd_sent) || (state == ST_WBACK);
    assign req.kind  = (state == ST_WBACK) ? ras_mem_pkg::cmd_write : ras_mem_pkg::cmd_read;
    assign req.addr  = cur_addr;
    assign req.wdata = wb_data;

    assign scrub_active = (state != ST_IDLE);

    // A step ends on a response that needs no repair, or when the
    // write-back is granted or cancelled by a newer host write
    always_comb begin
        step_done = 1'b0;
        if ((state == ST_READ) && scrub_rsp) begin
            step_done = !rsp.single_err || hit || host_wr_hit;
        end else if (state == ST_WBACK) begin
            step_done = req.ready || host_wr_hit;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= ST_IDLE;
            cur_addr  <= '0;
            rd_sent   <= 1'b0;
            hit       <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            pass_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (enable) begin
                        state   <= ST_READ;
                        rd_sent <= 1'b0;
                    end
                end
                ST_READ: begin
                    if (req.valid && req.ready) begin
                        rd_sent <= 1'b1;
                        hit     <= 1'b0;
                    end else if (host_wr_hit && rd_sent) begin
                        hit <= 1'b1;
                    end
                    if (scrub_rsp && !step_done) begin
                        state <= ST_WBACK;
                    end
                end
                default: begin
                end
            endcase
            // Enable is only sampled here, between steps
            if (step_done) begin
                cur_addr  <= cur_addr + 1'b1;
                pass_done <= (cur_addr == ras_mem_pkg::addr_t'(`RM_DEPTH - 1));
                rd_sent   <= 1'b0;
                state     <= enable ? ST_READ : ST_IDLE;
            end
        end
    end

    // Corrected word from the scrub read, written back unchanged
    always_ff @(posedge CLK) begin
        if (scrub_rsp) begin
            wb_data <= rsp.data;
        end
    end

endmodule

//--- source/ras_registers.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module ras_registers (
    input  logic                  CLK,
    input  logic                  RESET,
    input  ras_mem_pkg::mem_rsp_t rsp,
    input  logic                  pass_done,
    input  logic                  scrub_active,
    input  logic [7:0]            reg_addr,
    output logic [31:0]           reg_data,
    output logic                  irq_corr,
    output logic                  irq_uncorr
);

    logic [31:0]         corr_cnt;
    logic [31:0]         uncorr_cnt;
    logic [31:0]         pass_cnt;
    ras_mem_pkg::addr_t  err_addr;
    ras_mem_pkg::check_t err_syn;
    logic                corr_hit;
    logic                uncorr_hit;

    // Host and scrub responses are counted alike
    assign corr_hit   = rsp.valid && rsp.single_err;
    assign uncorr_hit = rsp.valid && rsp.double_err;

    // --------------------
    // Counters and capture
    // --------------------

    always_ff @(posedge CLK) begin
        if (RESET) begin
            corr_cnt   <= '0;
            uncorr_cnt <= '0;
            pass_cnt   <= '0;
            err_addr   <= '0;
            err_syn    <= '0;
            irq_corr   <= 1'b0;
            irq_uncorr <= 1'b0;
        end else begin
            if (corr_hit) begin
                // Counters stop at all ones rather than wrap
                if (corr_cnt != '1) begin
                    corr_cnt <= corr_cnt + 1'b1;
                end
                // Raised on the same edge as the count that reaches the threshold
                if (corr_cnt >= 32'(`RM_CORR_THRESHOLD - 1)) begin
                    irq_corr <= 1'b1;
                end
            end
            if (uncorr_hit) begin
                if (uncorr_cnt != '1) begin
                    uncorr_cnt <= uncorr_cnt + 1'b1;
                end
                irq_uncorr <= 1'b1;
            end
            // Latest error of either kind wins
            if (corr_hit || uncorr_hit) begin
                err_addr <= rsp.addr;
                err_syn  <= rsp.syndrome;
            end
            if (pass_done && (pass_cnt != '1)) begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    // Register read mux, unmapped indexes read zero
    always_comb begin
        case (reg_addr)
            `RM_REG_CORR_CNT:     reg_data = corr_cnt;
            `RM_REG_UNCORR_CNT:   reg_data = uncorr_cnt;
            `RM_REG_ERR_ADDR:     reg_data = 32'(err_addr);
            `RM_REG_SYNDROME:     reg_data = 32'(err_syn);
            `RM_REG_SCRUB_PASSES: reg_data = pass_cnt;
            `RM_REG_STATUS:       reg_data = {29'd0, irq_uncorr, irq_corr, scrub_active};
            default:              reg_data = '0;
        endcase
    end

endmodule

//--- source/ras_memory_controller.sv
`timescale 1ns/10ps

module ras_memory_controller (
    input  logic                   CLK,
    input  logic                   RESET,
    // Host command port
    input  logic                   cmd_valid,
    input  ras_mem_pkg::cmd_kind_t cmd_kind,
    input  ras_mem_pkg::addr_t     cmd_addr,
    input  ras_mem_pkg::word_t     cmd_wdata,
    output logic                   cmd_ready,
    // Host read return
    output logic                   rd_valid,
    output ras_mem_pkg::addr_t     rd_addr,
    output ras_mem_pkg::word_t     rd_data,
    output logic                   single_err,
    output logic                   double_err,
    // Scrub control and RAS reporting
    input  logic                   scrub_enable,
    output logic                   scrub_active,
    input  logic [7:0]             reg_addr,
    output logic [31:0]            reg_data,
    output logic                   irq_corr,
    output logic                   irq_uncorr
);

    ras_mem_pkg::mem_rsp_t rsp;
    logic                  pass_done;

    // Scrubber to arbiter, and arbiter to store
    mem_req_if scrub_req ();
    mem_req_if store_req ();

    cmd_arbiter u_arbiter (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_kind  (cmd_kind),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_ready (cmd_ready),
        .scrub     (scrub_req),
        .store     (store_req)
    );

    protected_store u_store (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (store_req),
        .rsp   (rsp)
    );

    // The scrubber also watches the store side for host writes
    patrol_scrubber u_scrubber (
        .CLK          (CLK),
        .RESET        (RESET),
        .enable       (scrub_enable),
        .req          (scrub_req),
        .bus          (store_req),
        .rsp          (rsp),
        .scrub_active (scrub_active),
        .pass_done    (pass_done)
    );

    ras_registers u_regs (
        .CLK          (CLK),
        .RESET        (RESET),
        .rsp          (rsp),
        .pass_done    (pass_done),
        .scrub_active (scrub_active),
        .reg_addr     (reg_addr),
        .reg_data     (reg_data),
        .irq_corr     (irq_corr),
        .irq_uncorr   (irq_uncorr)
    );

    // Only host responses reach the read port
    assign rd_valid   = rsp.valid && (rsp.src == ras_mem_pkg::src_host);
    assign rd_addr    = rsp.addr;
    assign rd_data    = rsp.data;
    assign single_err = rd_valid && rsp.single_err;
    assign double_err = rd_valid && rsp.double_err;

endmodule

//--- bench/ras_memory_properties.sv
`timescale 1ns/10ps

module ras_memory_properties (
    input logic CLK,
    input logic RESET,
    input logic rd_valid,
    input logic single_err,
    input logic double_err,
    input logic scrub_enable,
    input logic scrub_active,
    input logic irq_uncorr
);

    // Goes high once scrub_enable has been seen high since reset
    logic enable_seen;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            enable_seen <= 1'b0;
        end else if (scrub_enable) begin
            enable_seen <= 1'b1;
        end
    end

    a_flags_exclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(single_err && double_err))
        else $error("single_err and double_err are high together");

    a_flags_need_valid: assert property (@(posedge CLK) disable iff (RESET)
        (single_err || double_err) |-> rd_valid)
        else $error("error flag is high without rd_valid");

    a_scrub_quiet: assert property (@(posedge CLK) disable iff (RESET)
        (!enable_seen && !scrub_enable) |-> !scrub_active)
        else $error("scrub_active rose before scrubbing was ever enabled");

    // Only a reset on the previous edge may clear the sticky interrupt
    a_uncorr_sticky: assert property (@(posedge CLK)
        $fell(irq_uncorr) |-> $past(RESET))
        else $error("irq_uncorr fell without a reset");

endmodule

bind ras_memory_controller ras_memory_properties u_props (
    .CLK          (CLK),
    .RESET        (RESET),
    .rd_valid     (rd_valid),
    .single_err   (single_err),
    .double_err   (double_err),
    .scrub_enable (scrub_enable),
    .scrub_active (scrub_active),
    .irq_uncorr   (irq_uncorr)
);

//--- bench/tb_ras_memory.sv
`timescale 1ns/10ps
`include "ras_mem_config.svh"

module tb_ras_memory;

    localparam int NUM_OPS = 300;
    // Random traffic plus two full scrub passes at about four cycles a word and some margin
    localparam int TIMEOUT_CYCLES = 4 * (NUM_OPS + 2 * `RM_DEPTH * 4) + 1000;

    // One outstanding host read and the cycle its response is due
    typedef struct packed {
        ras_mem_pkg::addr_t addr;
        ras_mem_pkg::word_t data;
        logic               single_err;
        logic               double_err;
        logic [31:0]        due;
    } rd_expect_t;

    logic                   CLK;
    logic                   RESET;
    logic                   cmd_valid;
    ras_mem_pkg::cmd_kind_t cmd_kind;
    ras_mem_pkg::addr_t     cmd_addr;
    ras_mem_pkg::word_t     cmd_wdata;
    logic                   cmd_ready;
    logic                   rd_valid;
    ras_mem_pkg::addr_t     rd_addr;
    ras_mem_pkg::word_t     rd_data;
    logic                   single_err;
    logic                   double_err;
    logic                   scrub_enable;
    logic                   scrub_active;
    logic [7:0]             reg_addr;
    logic [31:0]            reg_data;
    logic                   irq_corr;
    logic                   irq_uncorr;

    // Model of the store where the kind of the last write says how it was poisoned
    ras_mem_pkg::word_t     model_data [`RM_DEPTH];
    ras_mem_pkg::cmd_kind_t model_kind [`RM_DEPTH];
    rd_expect_t             exp_q [$];
    int                     cycle;
    logic                   saw_stall;

    ras_memory_controller u_dut (.*);

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    // --------------------
    // Reference and checks
    // --------------------

    // Expected host read result follows the injection rule of each write kind
    function automatic ras_mem_pkg::word_t expected_read(input ras_mem_pkg::addr_t a,
                                                          output logic s, output logic d);
        s = 1'b0;
        d = 1'b0;
        case (model_kind[a])
            // A single flipped bit is repaired on the way out
            ras_mem_pkg::cmd_write_flip1: s = 1'b1;
            ras_mem_pkg::cmd_write_flip2: begin
                d = 1'b1;
                return model_data[a] ^ ras_mem_pkg::word_t'(3);
            end
            default: s = 1'b0;
        endcase
        return model_data[a];
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input ras_mem_pkg::word_t got,
                              input ras_mem_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input ras_mem_pkg::addr_t got,
                              input ras_mem_pkg::addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Responses are popped in order and must land exactly two cycles after acceptance
    always @(negedge CLK) begin
        rd_expect_t e;
        if (cycle >= TIMEOUT_CYCLES) begin
            fail_run("the run went past its cycle limit without finishing");
        end else if (!RESET && rd_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("a read response came back with no host read outstanding");
            end else begin
                e = exp_q.pop_front();
                check_reg("rd_valid cycle", 32'(cycle), e.due);
                check_addr("rd_addr", rd_addr, e.addr);
                check_word("rd_data", rd_data, e.data);
                check_flag("single_err", single_err, e.single_err);
                check_flag("double_err", double_err, e.double_err);
            end
        end else if (exp_q.size() != 0 && 32'(cycle) >= exp_q[0].due) begin
            fail_run("an expected read response never arrived");
        end
    end

    // --------------------
    // Drive tasks
    // --------------------

    // Holds the command until cmd_ready and then updates the model or queues the read
    task automatic issue(input ras_mem_pkg::cmd_kind_t kind, input ras_mem_pkg::addr_t a,
                         input ras_mem_pkg::word_t d);
        rd_expect_t e;
        logic       s;
        logic       dbl;
        @(negedge CLK);
        cmd_valid = 1'b1;
        cmd_kind  = kind;
        cmd_addr  = a;
        cmd_wdata = d;
        #1;
        while (cmd_ready !== 1'b1) begin
            saw_stall = 1'b1;
            @(negedge CLK);
            #1;
        end
        // Accepted on the coming rising edge
        if (kind == ras_mem_pkg::cmd_read) begin
            e.addr       = a;
            e.data       = expected_read(a, s, dbl);
            e.single_err = s;
            e.double_err = dbl;
            e.due        = 32'(cycle + 3);
            exp_q.push_back(e);
        end else begin
            model_data[a] = d;
            model_kind[a] = kind;
        end
    endtask

    task automatic read_reg(input logic [7:0] idx, output logic [31:0] val);
        @(negedge CLK);
        cmd_valid = 1'b0;
        reg_addr  = idx;
        #1;
        val = reg_data;
    endtask

    // Waits for every queued read and one more edge so the counters settle
    task automatic drain();
        do begin
            @(negedge CLK);
            cmd_valid = 1'b0;
            #1;
        end while (exp_q.size() != 0);
        @(negedge CLK);
    endtask

    task automatic scrub_off();
        @(negedge CLK);
        cmd_valid    = 1'b0;
        scrub_enable = 1'b0;
        // The step in progress finishes before the scrubber goes idle
        do begin
            @(negedge CLK);
            #1;
        end while (scrub_active);
    endtask

    // --------------------
    // Test sequences
    // --------------------

    task automatic plain_traffic();
        ras_mem_pkg::addr_t a;
        for (int i = 0; i < NUM_OPS; i++) begin
            // Small address window so reads often hit written words
            a = ras_mem_pkg::addr_t'($urandom % 64);
            if ($urandom % 2) begin
                issue(ras_mem_pkg::cmd_write, a, {$urandom, $urandom});
            end else begin
                issue(ras_mem_pkg::cmd_read, a, '0);
            end
        end
        drain();
    endtask

    task automatic single_error_reads();
        logic [31:0] val;
        ras_mem_pkg::addr_t a;
        for (int i = 0; i < `RM_CORR_THRESHOLD; i++) begin
            a = ras_mem_pkg::addr_t'(100 + i);
            issue(ras_mem_pkg::cmd_write_flip1, a, {$urandom, $urandom});
            issue(ras_mem_pkg::cmd_read, a, '0);
            drain();
            read_reg(`RM_REG_CORR_CNT, val);
            check_reg("corr_cnt", val, 32'(i + 1));
            check_flag("irq_corr", irq_corr, (i + 1) >= `RM_CORR_THRESHOLD);
        end
        // Clean these words again so only the scrub test counts a repair
        for (int i = 0; i < `RM_CORR_THRESHOLD; i++) begin
            issue(ras_mem_pkg::cmd_write, ras_mem_pkg::addr_t'(100 + i), {$urandom, $urandom});
        end
    endtask

    task automatic double_error_read();
        logic [31:0] base;
        logic [31:0] val;
        read_reg(`RM_REG_UNCORR_CNT, base);
        check_flag("irq_uncorr", irq_uncorr, 1'b0);
        issue(ras_mem_pkg::cmd_write_flip2, ras_mem_pkg::addr_t'(200), {$urandom, $urandom});
        issue(ras_mem_pkg::cmd_read, ras_mem_pkg::addr_t'(200), '0);
        drain();
        read_reg(`RM_REG_UNCORR_CNT, val);
        check_reg("uncorr_cnt", val, base + 1);
        read_reg(`RM_REG_ERR_ADDR, val);
        check_reg("err_addr", val, 32'd200);
        // Data bits 0 and 1 sit at codeword positions 3 and 5 and their syndrome is 3 XOR 5
        read_reg(`RM_REG_SYNDROME, val);
        check_reg("syndrome", val, 32'h06);
        check_flag("irq_uncorr", irq_uncorr, 1'b1);
    endtask

    task automatic scrub_repair();
        logic [31:0] base;
        logic [31:0] val;
        issue(ras_mem_pkg::cmd_write_flip1, ras_mem_pkg::addr_t'(300), {$urandom, $urandom});
        read_reg(`RM_REG_CORR_CNT, base);
        @(negedge CLK);
        scrub_enable = 1'b1;
        do begin
            read_reg(`RM_REG_SCRUB_PASSES, val);
            check_flag("scrub_active", scrub_active, 1'b1);
        end while (val != 32'd1);
        scrub_off();
        // Both interrupts are still pending from the injection tests and the scrubber is idle
        read_reg(`RM_REG_STATUS, val);
        check_reg("status", val, 32'h6);
        // The scrubber wrote back the corrected word
        model_kind[300] = ras_mem_pkg::cmd_write;
        issue(ras_mem_pkg::cmd_read, ras_mem_pkg::addr_t'(300), '0);
        drain();
        read_reg(`RM_REG_CORR_CNT, val);
        check_reg("corr_cnt", val, base + 1);
    endtask

    task automatic contention();
        logic [31:0] base;
        logic [31:0] val;
        int          r;
        read_reg(`RM_REG_SCRUB_PASSES, base);
        saw_stall = 1'b0;
        @(negedge CLK);
        scrub_enable = 1'b1;
        for (int i = 0; i < NUM_OPS; i++) begin
            r = $urandom % 3;
            // Without single-bit poison the scrubber never alters a host read
            issue(r == 0 ? ras_mem_pkg::cmd_read :
                  r == 1 ? ras_mem_pkg::cmd_write : ras_mem_pkg::cmd_write_flip2,
                  ras_mem_pkg::addr_t'($urandom), {$urandom, $urandom});
        end
        do begin
            read_reg(`RM_REG_SCRUB_PASSES, val);
        end while (val <= base);
        scrub_off();
        drain();
        if (!saw_stall) begin
            fail_run("cmd_ready never went low while the scrubber competed");
        end
    endtask

    initial begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_kind     = ras_mem_pkg::cmd_read;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        scrub_enable = 1'b0;
        reg_addr     = '0;
        cycle        = 0;
        saw_stall    = 1'b0;
        void'($urandom(32'hd890_5180));
        // Reset leaves every word as a clean zero codeword
        for (int i = 0; i < `RM_DEPTH; i++) begin
            model_data[i] = '0;
            model_kind[i] = ras_mem_pkg::cmd_write;
        end
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        plain_traffic();
        single_error_reads();
        double_error_read();
        scrub_repair();
        contention();
        if (exp_q.size() != 0) begin
            fail_run("host reads were still outstanding at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+common
common/ras_mem_pkg.sv
common/mem_req_if.sv
ecc/secded_encoder.sv
ecc/secded_decoder.sv
source/cmd_arbiter.sv
source/protected_store.sv
source/patrol_scrubber.sv
source/ras_registers.sv
source/ras_memory_controller.sv
bench/ras_memory_properties.sv
bench/tb_ras_memory.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide on the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_ras_memory --Mdir obj_dir -o tb_ras_memory \
    && ./obj_dir/tb_ras_memory | tee /dev/stderr | grep -q "test passed" \
    && echo "simulation finished: PASS" \
    || { echo "simulation finished: FAIL"; exit 1; }

exit 0
